//--- rtl/scatter_pkg.sv
`default_nettype none

package scatter_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int DATA_BYTES    = 4;
    localparam int BUF_WORDS     = 4;
    localparam int NUM_BUFS      = 16;
    localparam int PTR_WID       = $clog2(NUM_BUFS);
    localparam int ADDR_WID      = PTR_WID + $clog2(BUF_WORDS);
    localparam int MIN_PKT_SIZE  = 8;
    localparam int MAX_PKT_SIZE  = 48;
    localparam int MAX_PKT_WORDS = MAX_PKT_SIZE / DATA_BYTES;
    localparam int SIZE_WID      = 7;
    localparam int META_WID      = 8;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [PTR_WID-1:0] ptr_t;

    // One input beat
    typedef struct packed {
        logic [DATA_BYTES*8-1:0]      data;
        logic                         sop;
        logic                         eop;
        logic [$clog2(DATA_BYTES)-1:0] mty;
        logic                         err;
        logic [META_WID-1:0]          meta;
    } pkt_word_t;

    typedef enum logic [1:0] {
        STATUS_OK,
        STATUS_SHORT,
        STATUS_LONG,
        STATUS_ERR
    } pkt_status_t;

    typedef struct packed {
        ptr_t                head;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
    } pkt_desc_t;

    typedef struct packed {
        logic [SIZE_WID-1:0] size;
        pkt_status_t         status;
    } pkt_event_t;

    typedef enum logic [2:0] {
        WAIT_INIT,
        SOP,
        MOP,
        NXT_BUF,
        FLUSH
    } wr_state_t;

endpackage : scatter_pkg

`default_nettype wire

//--- rtl/pkt_mem.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_mem (
    input  logic                             clk,
    input  logic                             mem_wr,
    input  logic [scatter_pkg::ADDR_WID-1:0] mem_addr,
    input  logic [31:0]                      mem_data,
    input  logic                             rd_req,
    input  logic [scatter_pkg::ADDR_WID-1:0] rd_addr,
    output logic [31:0]                      rd_data
);
    import scatter_pkg::*;

    logic [31:0] mem [NUM_BUFS*BUF_WORDS];

    always_ff @(posedge clk) begin
        if (mem_wr) mem[mem_addr] <= mem_data;
    end

    // Read data arrives one cycle after rd_req
    always_ff @(posedge clk) begin
        if (rd_req) rd_data <= mem[rd_addr];
    end

endmodule : pkt_mem

`default_nettype wire

//--- rtl/buffer_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_alloc (
    input  logic              clk,
    input  logic              srst,
    input  logic              alloc_req,
    output logic              alloc_rdy,
    output scatter_pkg::ptr_t alloc_ptr,
    input  logic              link_wr,
    input  logic              link_last,
    input  scatter_pkg::ptr_t link_ptr,
    input  scatter_pkg::ptr_t link_nxt,
    input  logic              recycle_req,
    input  scatter_pkg::ptr_t recycle_ptr,
    input  logic              rel_req,
    input  scatter_pkg::ptr_t rel_ptr,
    output logic [4:0]        free_cnt,
    output logic              init_done
);
    import scatter_pkg::*;

    // Free pointer FIFO
    ptr_t        free_mem [NUM_BUFS];
    ptr_t        free_rd;
    ptr_t        free_wr;
    logic        free_push;
    logic        free_pop;
    ptr_t        free_push_ptr;

    // Initial fill of the pool
    logic [4:0]  fill_cnt;
    logic        fill_push;

    // Next pointer and end flag per buffer
    ptr_t        link_nxt_mem [NUM_BUFS];
    logic        link_last_mem [NUM_BUFS];

    // Release queue shared by recycle and release
    ptr_t        q_mem [4];
    logic [1:0]  q_rd;
    logic [1:0]  q_wr;
    logic [1:0]  rel_slot;
    logic [1:0]  q_push_n;
    logic [2:0]  q_cnt;
    logic        q_pop;

    // Chain walker
    logic        walk_active;
    ptr_t        walk_ptr;
    logic        walk_last;

    // ----------------------------------------
    // Free list
    // ----------------------------------------
    assign init_done = (fill_cnt == 5'(NUM_BUFS));
    assign fill_push = !init_done && !walk_active;

    // Walker wins over the fill
    assign free_push     = walk_active || fill_push;
    assign free_push_ptr = walk_active ? walk_ptr : fill_cnt[PTR_WID-1:0];

    assign alloc_rdy = (free_cnt != '0);
    assign alloc_ptr = free_mem[free_rd];
    assign free_pop  = alloc_req && alloc_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            free_rd  <= '0;
            free_wr  <= '0;
            free_cnt <= '0;
            fill_cnt <= '0;
        end else begin
            if (free_push) free_wr <= free_wr + 1'b1;
            if (free_pop) free_rd <= free_rd + 1'b1;
            if (fill_push) fill_cnt <= fill_cnt + 1'b1;
            free_cnt <= free_cnt + 5'(free_push) - 5'(free_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (free_push) free_mem[free_wr] <= free_push_ptr;
    end

    // ----------------------------------------
    // Link table
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (link_wr) begin
            link_nxt_mem[link_ptr]  <= link_nxt;
            link_last_mem[link_ptr] <= link_last;
        end
    end

    // ----------------------------------------
    // Release queue
    // ----------------------------------------
    // Recycle goes first when both requests land in one cycle
    assign q_push_n = 2'(recycle_req) + 2'(rel_req);
    assign rel_slot = q_wr + 2'(recycle_req);
    assign q_pop    = (q_cnt != '0) && (!walk_active || walk_last);

    always_ff @(posedge clk) begin
        if (recycle_req) q_mem[q_wr] <= recycle_ptr;
        if (rel_req) q_mem[rel_slot] <= rel_ptr;
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            q_rd  <= '0;
            q_wr  <= '0;
            q_cnt <= '0;
        end else begin
            q_wr  <= q_wr + q_push_n;
            if (q_pop) q_rd <= q_rd + 1'b1;
            q_cnt <= q_cnt + 3'(q_push_n) - 3'(q_pop);
        end
    end

    // ----------------------------------------
    // Chain walker
    // ----------------------------------------
    // One buffer freed per cycle until the end mark
    assign walk_last = link_last_mem[walk_ptr];

    always_ff @(posedge clk) begin
        if (srst) begin
            walk_active <= 1'b0;
        end else if (q_pop) begin
            walk_active <= 1'b1;
        end else if (walk_active && walk_last) begin
            walk_active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            walk_ptr <= q_mem[q_rd];
        end else if (walk_active) begin
            walk_ptr <= link_nxt_mem[walk_ptr];
        end
    end

endmodule : buffer_alloc

`default_nettype wire

//--- rtl/packet_scatter.sv
`timescale 1ns/1ps
`default_nettype none

module packet_scatter (
    input  logic                             clk,
    input  logic                             srst,
    input  logic                             init_done,
    input  logic                             in_valid,
    input  scatter_pkg::pkt_word_t           in_word,
    output logic                             in_rdy,
    output logic                             alloc_req,
    input  logic                             alloc_rdy,
    input  scatter_pkg::ptr_t                alloc_ptr,
    output logic                             link_wr,
    output logic                             link_last,
    output scatter_pkg::ptr_t                link_ptr,
    output scatter_pkg::ptr_t                link_nxt,
    output logic                             mem_wr,
    output logic [scatter_pkg::ADDR_WID-1:0] mem_addr,
    output logic [31:0]                      mem_data,
    output logic                             recycle_req,
    output scatter_pkg::ptr_t                recycle_ptr,
    output logic                             desc_valid,
    output logic                             evt_valid,
    output scatter_pkg::pkt_desc_t           desc,
    output scatter_pkg::pkt_event_t          evt
);
    import scatter_pkg::*;

    wr_state_t           state;
    wr_state_t           nxt_state;
    logic                acc;
    logic                take_buf;
    logic                go_flush;
    logic                last_mark;
    logic                last_pend;

    ptr_t                cur_ptr;
    ptr_t                buf_ptr;
    ptr_t                head_ptr;
    logic [2:0]          words;
    logic [1:0]          widx;
    logic [4:0]          pkt_words;

    // Context captured at eop
    logic [1:0]          eop_mty;
    logic                eop_err;
    logic [META_WID-1:0] eop_meta;

    logic                pkt_done;
    logic [SIZE_WID-1:0] pkt_size;
    pkt_status_t         pkt_status;
    logic                pkt_ok;

    // ----------------------------------------
    // Write FSM
    // ----------------------------------------
    always_comb begin
        case (state)
            SOP:     in_rdy = alloc_rdy;
            MOP:     in_rdy = (words < BUF_WORDS);
            NXT_BUF: in_rdy = alloc_rdy;
            FLUSH:   in_rdy = 1'b1;
            default: in_rdy = 1'b0;
        endcase
    end

    assign acc = in_valid && in_rdy;

    always_comb begin
        nxt_state = state;
        go_flush  = 1'b0;
        case (state)
            WAIT_INIT: begin
                if (init_done) nxt_state = SOP;
            end
            SOP: begin
                if (acc && !in_word.eop) nxt_state = MOP;
            end
            MOP, NXT_BUF: begin
                if (acc) begin
                    if (in_word.eop) begin
                        nxt_state = SOP;
                    end else if (pkt_words == MAX_PKT_WORDS - 1) begin
                        go_flush  = 1'b1;
                        nxt_state = FLUSH;
                    end else if (state == NXT_BUF) begin
                        nxt_state = MOP;
                    end else if (words == BUF_WORDS - 1) begin
                        nxt_state = NXT_BUF;
                    end
                end
            end
            FLUSH: begin
                if (acc && in_word.eop) nxt_state = SOP;
            end
            default: begin
                nxt_state = WAIT_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= WAIT_INIT;
            words     <= '0;
            pkt_done  <= 1'b0;
            last_pend <= 1'b0;
        end else begin
            state     <= nxt_state;
            pkt_done  <= acc && in_word.eop;
            last_pend <= last_mark;
            if (acc && state != FLUSH) words <= take_buf ? 3'd1 : words + 1'b1;
        end
    end

    // ----------------------------------------
    // Buffers and memory writes
    // ----------------------------------------
    // A new buffer is taken on the first word of each buffer
    assign take_buf  = (state == SOP) || (state == NXT_BUF);
    assign cur_ptr   = take_buf ? alloc_ptr : buf_ptr;
    assign widx      = take_buf ? 2'd0 : words[1:0];
    assign alloc_req = acc && take_buf;

    assign mem_wr   = acc && (state != FLUSH);
    assign mem_addr = ADDR_WID'(cur_ptr * BUF_WORDS) + ADDR_WID'(widx);
    assign mem_data = in_word.data;

    // End mark goes out the cycle after the last stored word
    // while buf_ptr still holds that buffer
    assign last_mark = acc && (state != FLUSH) && (in_word.eop || go_flush);

    assign link_wr   = last_pend || (acc && state == NXT_BUF);
    assign link_last = last_pend;
    assign link_ptr  = buf_ptr;
    assign link_nxt  = alloc_ptr;

    always_ff @(posedge clk) begin
        if (acc) begin
            buf_ptr <= cur_ptr;
            if (state == SOP) head_ptr <= alloc_ptr;
            // Saturates at 31 words
            if (in_word.sop) begin
                pkt_words <= 5'd1;
            end else if (pkt_words != '1) begin
                pkt_words <= pkt_words + 1'b1;
            end
            if (in_word.eop) begin
                eop_mty  <= in_word.mty;
                eop_err  <= in_word.err;
                eop_meta <= in_word.meta;
            end
        end
    end

    // ----------------------------------------
    // Packet status and outputs
    // ----------------------------------------
    assign pkt_size = SIZE_WID'(pkt_words * DATA_BYTES) - SIZE_WID'(eop_mty);

    always_comb begin
        if (eop_err) begin
            pkt_status = STATUS_ERR;
        end else if (pkt_size > MAX_PKT_SIZE) begin
            pkt_status = STATUS_LONG;
        end else if (pkt_size < MIN_PKT_SIZE) begin
            pkt_status = STATUS_SHORT;
        end else begin
            pkt_status = STATUS_OK;
        end
    end

    assign pkt_ok = (pkt_status == STATUS_OK);

    assign desc_valid = pkt_done && pkt_ok;
    assign desc       = '{head: head_ptr, size: pkt_size, meta: eop_meta};
    assign evt_valid  = pkt_done;
    assign evt        = '{size: pkt_size, status: pkt_status};

    // Dropped packets hand their chain straight back
    assign recycle_req = pkt_done && !pkt_ok;
    assign recycle_ptr = head_ptr;

endmodule : packet_scatter

`default_nettype wire

//--- rtl/scatter_top.sv
`timescale 1ns/1ps
`default_nettype none

module scatter_top (
    input  logic                             clk,
    input  logic                             srst,
    input  logic                             in_valid,
    input  scatter_pkg::pkt_word_t           in_word,
    output logic                             in_rdy,
    input  logic                             rel_req,
    input  scatter_pkg::ptr_t                rel_ptr,
    input  logic                             rd_req,
    input  logic [scatter_pkg::ADDR_WID-1:0] rd_addr,
    output logic [31:0]                      rd_data,
    output logic                             desc_valid,
    output scatter_pkg::pkt_desc_t           desc,
    output logic                             evt_valid,
    output scatter_pkg::pkt_event_t          evt,
    output logic [4:0]                       free_cnt,
    output logic                             init_done
);
    import scatter_pkg::*;

    // Writer to allocator
    logic                alloc_req;
    logic                alloc_rdy;
    ptr_t                alloc_ptr;
    logic                link_wr;
    logic                link_last;
    ptr_t                link_ptr;
    ptr_t                link_nxt;
    logic                recycle_req;
    ptr_t                recycle_ptr;

    // Writer to memory
    logic                mem_wr;
    logic [ADDR_WID-1:0] mem_addr;
    logic [31:0]         mem_data;

    packet_scatter u_scatter (
        .clk         (clk),
        .srst        (srst),
        .init_done   (init_done),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .in_rdy      (in_rdy),
        .alloc_req   (alloc_req),
        .alloc_rdy   (alloc_rdy),
        .alloc_ptr   (alloc_ptr),
        .link_wr     (link_wr),
        .link_last   (link_last),
        .link_ptr    (link_ptr),
        .link_nxt    (link_nxt),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .recycle_req (recycle_req),
        .recycle_ptr (recycle_ptr),
        .desc_valid  (desc_valid),
        .evt_valid   (evt_valid),
        .desc        (desc),
        .evt         (evt)
    );

    buffer_alloc u_alloc (
        .clk         (clk),
        .srst        (srst),
        .alloc_req   (alloc_req),
        .alloc_rdy   (alloc_rdy),
        .alloc_ptr   (alloc_ptr),
        .link_wr     (link_wr),
        .link_last   (link_last),
        .link_ptr    (link_ptr),
        .link_nxt    (link_nxt),
        .recycle_req (recycle_req),
        .recycle_ptr (recycle_ptr),
        .rel_req     (rel_req),
        .rel_ptr     (rel_ptr),
        .free_cnt    (free_cnt),
        .init_done   (init_done)
    );

    pkt_mem u_mem (
        .clk      (clk),
        .mem_wr   (mem_wr),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule : scatter_top

`default_nettype wire

//--- dv/scatter_sva.sv
`timescale 1ns/1ps
`default_nettype none

module scatter_sva (
    input logic       clk,
    input logic       srst,
    input logic       alloc_req,
    input logic       alloc_rdy,
    input logic [2:0] q_cnt,
    input logic [1:0] q_push_n,
    input logic       q_pop,
    input logic [4:0] free_cnt,
    input logic       desc_valid,
    input logic       evt_valid
);
    import scatter_pkg::*;

    // Number of failed assertions in this instance
    int err_cnt = 0;

    a_alloc_rdy: assert property (@(posedge clk) disable iff (srst) alloc_req |-> alloc_rdy)
        else begin
            $error("alloc_req high while alloc_rdy is low");
            err_cnt++;
        end

    // Four entry release queue
    a_queue_room: assert property (@(posedge clk) disable iff (srst)
        ({1'b0, q_cnt} + 4'(q_push_n)) <= (4'd4 + 4'(q_pop)))
        else begin
            $error("release queue overflow");
            err_cnt++;
        end

    a_desc_evt: assert property (@(posedge clk) disable iff (srst) desc_valid |-> evt_valid)
        else begin
            $error("desc_valid without evt_valid");
            err_cnt++;
        end

    a_free_cnt: assert property (@(posedge clk) disable iff (srst) free_cnt <= 5'(NUM_BUFS))
        else begin
            $error("free_cnt above pool size");
            err_cnt++;
        end

endmodule : scatter_sva

`default_nettype wire

//--- dv/scatter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scatter_tb;
    import scatter_pkg::*;

    logic                clk;
    logic                srst;
    logic                in_valid;
    pkt_word_t           in_word;
    logic                in_rdy;
    logic                rel_req;
    ptr_t                rel_ptr;
    logic                rd_req;
    logic [ADDR_WID-1:0] rd_addr;
    logic [31:0]         rd_data;
    logic                desc_valid;
    pkt_desc_t           desc;
    logic                evt_valid;
    pkt_event_t          evt;
    logic [4:0]          free_cnt;
    logic                init_done;

    // Test table with one entry per packet
    int          t_words[$];
    int          t_mty[$];
    int          t_err[$];
    int          t_meta[$];
    logic [31:0] t_start[$];
    int          t_size[$];
    int          t_status[$];
    int          t_desc[$];
    int          n_tests;

    // Reference free list and the chain of every stored packet
    ptr_t        free_model[$];
    logic [MAX_PKT_WORDS/BUF_WORDS*PTR_WID-1:0] chain_map [NUM_BUFS];
    int          chain_len [NUM_BUFS];
    ptr_t        rel_heads[$];
    int          rel_idx[$];
    int          pending_rel;

    // Eop beat seen ready at the last falling edge
    logic        eop_acc;

    int          evt_cnt;
    int          stall_cycles;
    int          cycles;
    int          limit;
    int          i;

    scatter_top DUT (
        .clk        (clk),
        .srst       (srst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_rdy     (in_rdy),
        .rel_req    (rel_req),
        .rel_ptr    (rel_ptr),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .desc_valid (desc_valid),
        .desc       (desc),
        .evt_valid  (evt_valid),
        .evt        (evt),
        .free_cnt   (free_cnt),
        .init_done  (init_done)
    );

    bind buffer_alloc scatter_sva u_alloc_sva (
        .clk        (clk),
        .srst       (srst),
        .alloc_req  (alloc_req),
        .alloc_rdy  (alloc_rdy),
        .q_cnt      (q_cnt),
        .q_push_n   (q_push_n),
        .q_pop      (q_pop),
        .free_cnt   (free_cnt),
        .desc_valid (1'b0),
        .evt_valid  (1'b0)
    );

    bind packet_scatter scatter_sva u_scatter_sva (
        .clk        (clk),
        .srst       (srst),
        .alloc_req  (alloc_req),
        .alloc_rdy  (alloc_rdy),
        .q_cnt      (3'd0),
        .q_push_n   (2'd0),
        .q_pop      (1'b0),
        .free_cnt   (5'd0),
        .desc_valid (desc_valid),
        .evt_valid  (evt_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------
    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string why);
        $display("** Error at %0t ns: %s", $time, why);
        stop_run();
    endtask

    task automatic check_desc(input pkt_desc_t act, input pkt_desc_t exp);
        string a_s;
        string e_s;
        if (act !== exp) begin
            a_s = $sformatf("{head %0d, size %0d, meta %h}", act.head, act.size, act.meta);
            e_s = $sformatf("{head %0d, size %0d, meta %h}", exp.head, exp.size, exp.meta);
            $display("** Error at %0t ns: desc = %s, expected %s", $time, a_s, e_s);
            stop_run();
        end
    endtask

    task automatic check_evt(input pkt_event_t act, input pkt_event_t exp);
        string a_s;
        string e_s;
        if (act !== exp) begin
            a_s = $sformatf("{size %0d, status %s}", act.size, act.status.name());
            e_s = $sformatf("{size %0d, status %s}", exp.size, exp.status.name());
            $display("** Error at %0t ns: evt = %s, expected %s", $time, a_s, e_s);
            stop_run();
        end
    endtask

    task automatic check_word(input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("** Error at %0t ns: rd_data = %h, expected %h", $time, act, exp);
            stop_run();
        end
    endtask

    // ----------------------------------------
    // Test file and stimulus
    // ----------------------------------------
    task automatic load_tests();
        int          fd;
        int          rc;
        string       line;
        int          words;
        int          mty;
        int          err;
        int          meta;
        int          size;
        int          status;
        int          has_desc;
        logic [31:0] start;
        fd = $fopen("dv/scatter_tests.txt", "r");
        if (fd == 0) report_failure("cannot open dv/scatter_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
                rc = $sscanf(line, "%d %d %d %h %h %d %d %d",
                             words, mty, err, meta, start, size, status, has_desc);
                if (rc == 8) begin
                    t_words.push_back(words);
                    t_mty.push_back(mty);
                    t_err.push_back(err);
                    t_meta.push_back(meta);
                    t_start.push_back(start);
                    t_size.push_back(size);
                    t_status.push_back(status);
                    t_desc.push_back(has_desc);
                end
            end
        end
        $fclose(fd);
        n_tests = t_words.size();
        if (n_tests == 0) report_failure("no packets found in dv/scatter_tests.txt");
    endtask

    task automatic send_beat(input pkt_word_t beat);
        in_valid = 1'b1;
        in_word  = beat;
        @(negedge clk);
        while (!in_rdy) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_packet(input int idx);
        pkt_word_t beat;
        int        w;
        for (w = 0; w < t_words[idx]; w++) begin
            beat      = '0;
            beat.data = t_start[idx] + w;
            beat.sop  = (w == 0);
            beat.eop  = (w == t_words[idx] - 1);
            // Status fields only matter on the last beat
            if (beat.eop) begin
                beat.mty  = 2'(t_mty[idx]);
                beat.err  = (t_err[idx] != 0);
                beat.meta = META_WID'(t_meta[idx]);
            end
            send_beat(beat);
        end
    endtask

    task automatic read_word(input logic [ADDR_WID-1:0] addr, output logic [31:0] data);
        rd_req  = 1'b1;
        rd_addr = addr;
        @(posedge clk);
        #1;
        rd_req = 1'b0;
        @(negedge clk);
        data = rd_data;
        @(posedge clk);
        #1;
    endtask

    // ----------------------------------------
    // Free list reference
    // ----------------------------------------
    task automatic return_chain(input ptr_t head);
        int j;
        for (j = 0; j < chain_len[head]; j++) begin
            free_model.push_back(chain_map[head][j*PTR_WID +: PTR_WID]);
        end
    endtask

    task automatic score_event();
        int         idx;
        int         nb;
        int         j;
        ptr_t       head;
        ptr_t       p;
        pkt_event_t exp_evt;
        pkt_desc_t  exp_desc;
        if (evt_cnt >= n_tests) report_failure("event with no packet left to match");
        idx = evt_cnt;
        // Flushed packets keep only the first 12 words
        nb = (t_words[idx] > MAX_PKT_WORDS) ? MAX_PKT_WORDS : t_words[idx];
        nb = (nb + BUF_WORDS - 1) / BUF_WORDS;
        head = '0;
        for (j = 0; j < nb; j++) begin
            if (free_model.size() == 0) report_failure("reference free list ran empty");
            p = free_model.pop_front();
            if (j == 0) head = p;
            chain_map[head][j*PTR_WID +: PTR_WID] = p;
        end
        chain_len[head] = nb;
        exp_evt.size   = SIZE_WID'(t_size[idx]);
        exp_evt.status = pkt_status_t'(t_status[idx]);
        check_evt(evt, exp_evt);
        if (t_desc[idx] != 0) begin
            if (desc_valid !== 1'b1) report_failure("descriptor missing for a good packet");
            exp_desc.head = head;
            exp_desc.size = SIZE_WID'(t_size[idx]);
            exp_desc.meta = META_WID'(t_meta[idx]);
            check_desc(desc, exp_desc);
            rel_heads.push_back(head);
            rel_idx.push_back(idx);
            pending_rel++;
        end else begin
            if (desc_valid !== 1'b0) report_failure("descriptor for a dropped packet");
            return_chain(head);
        end
        evt_cnt++;
    endtask

    // Recycle before release when both land in one cycle
    always @(negedge clk) begin
        if (!srst) begin
            if (DUT.u_alloc.u_alloc_sva.err_cnt + DUT.u_scatter.u_scatter_sva.err_cnt != 0)
                report_failure("an assertion in scatter_sva failed");
            if (desc_valid === 1'b1 && evt_valid !== 1'b1)
                report_failure("descriptor without an event");
            // Event strobe comes one cycle after the eop beat transfers
            if (evt_valid !== eop_acc)
                report_failure("event strobe not on the cycle after the eop beat");
            if (evt_valid === 1'b1) score_event();
            if (rel_req === 1'b1) return_chain(rel_ptr);
            eop_acc = in_valid && in_rdy && in_word.eop;
        end
    end

    // Consumer checks the first buffer and then releases the head
    initial begin
        int          dly;
        int          idx;
        int          nrd;
        int          k;
        ptr_t        head;
        logic [31:0] data;
        dly = $urandom(25);
        forever begin
            while (rel_heads.size() == 0) @(posedge clk);
            dly = 20 + $urandom % 40;
            repeat (dly) @(posedge clk);
            #1;
            head = rel_heads.pop_front();
            idx  = rel_idx.pop_front();
            nrd  = (t_words[idx] < BUF_WORDS) ? t_words[idx] : BUF_WORDS;
            for (k = 0; k < nrd; k++) begin
                read_word(ADDR_WID'(head * BUF_WORDS + k), data);
                check_word(data, t_start[idx] + k);
            end
            rel_req = 1'b1;
            rel_ptr = head;
            @(posedge clk);
            #1;
            rel_req = 1'b0;
            pending_rel--;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) report_failure($sformatf("timeout after %0d cycles", limit));
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        srst         = 1'b1;
        in_valid     = 1'b0;
        in_word      = '0;
        rel_req      = 1'b0;
        rel_ptr      = '0;
        rd_req       = 1'b0;
        rd_addr      = '0;
        eop_acc      = 1'b0;
        evt_cnt      = 0;
        stall_cycles = 0;
        pending_rel  = 0;
        for (i = 0; i < NUM_BUFS; i++) free_model.push_back(ptr_t'(i));
        load_tests();
        limit = 200 * n_tests + 100;

        repeat (2) @(posedge clk);
        #1;
        srst = 1'b0;
        // Wait for the pool fill and for the writer to leave WAIT_INIT
        do @(negedge clk); while (!(init_done && in_rdy));
        @(posedge clk);
        #1;

        for (i = 0; i < n_tests; i++) send_packet(i);
        in_valid = 1'b0;
        in_word  = '0;

        while (evt_cnt < n_tests) @(negedge clk);
        while (pending_rel != 0) @(negedge clk);
        while (free_cnt != 5'(NUM_BUFS)) @(negedge clk);

        if (stall_cycles > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_failure("input back-pressure never happened");
        end
    end

endmodule : scatter_tb

`default_nettype wire

//--- scatter_top.f
rtl/scatter_pkg.sv
rtl/pkt_mem.sv
rtl/buffer_alloc.sv
rtl/packet_scatter.sv
rtl/scatter_top.sv
dv/scatter_sva.sv
dv/scatter_tb.sv

//--- dv/scatter_tests.txt
# words mty err meta(hex) start(hex) exp_size exp_status exp_desc
# status codes 0 OK, 1 SHORT, 2 LONG, 3 ERR; exp_desc is 1 when a descriptor is expected
2  0 0 11 00001000 8   0 1
4  0 0 12 00002000 16  0 1
9  0 0 13 00003000 36  0 1
1  0 0 14 00004000 4   1 0
2  1 0 15 00005000 7   1 0
5  3 0 16 00006000 17  0 1
12 0 0 17 00007000 48  0 1
13 0 0 18 00008000 52  2 0
12 3 0 19 00009000 45  0 1
3  0 1 1a 0000a000 12  3 0
20 2 0 1b 0000b000 78  2 0
8  0 0 1c 0000c000 32  0 1
9  1 0 1d 0000d000 35  0 1
9  2 0 1e 0000e000 34  0 1
10 0 0 1f 0000f000 40  0 1
11 0 1 20 00010000 44  3 0
9  0 0 21 00011000 36  0 1
12 1 0 22 00012000 47  0 1
4  0 0 23 00013000 16  0 1
6  2 0 24 00014000 22  0 1
9  3 0 25 00015000 33  0 1
14 1 1 26 00016000 55  3 0
3  0 0 27 00017000 12  0 1
1  3 0 28 00018000 1   1 0
9  0 0 29 00019000 36  0 1
7  0 0 2a 0001a000 28  0 1
33 0 0 2b 0001b000 124 2 0
